//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = pipeCtrlTb
FILELIST  = tb.f
BUILDDIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	@out=$$(./$(BUILDDIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILDDIR)

//--- bench/pipeCtrlTb.sv
module pipeCtrlTb import pipeCtrlPkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int traceLen    = 64;
  localparam int resetCycles = 10;
  // reset, every trace line, and some slack
  localparam int cycleLimit  = resetCycles + traceLen + 20;
  localparam string traceFile = "bench/pipeCtrlTrace.txt";
  // unused words keep this value, no real line can hold it
  localparam logic [83:0] sentinel = '1;

  logic     clk = 1'b0;
  logic     rst;
  logic     fetchValid;
  regIdxT   fetchSrc1;
  regIdxT   fetchSrc2;
  regIdxT   fetchDest;
  logic     fetchRegWrite;
  logic     fetchMemToReg;
  logic     dStall;
  logic     iStall;
  logic     branchTakenE;
  excCauseT exc;
  logic     queueFull;
  fwdSelT   forwardAE;
  fwdSelT   forwardBE;
  logic     stallF;
  logic     stallD;
  logic     flushD;
  logic     flushE;
  vecSelT   pcInSelect;
  logic     retireValid;
  regIdxT   retireDest;

  logic [83:0] trace [traceLen];
  int          cycleCount = 0;

  pipeCtrlTop DUT (
    .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchSrc1(fetchSrc1),
    .fetchSrc2(fetchSrc2), .fetchDest(fetchDest), .fetchRegWrite(fetchRegWrite),
    .fetchMemToReg(fetchMemToReg), .dStall(dStall), .iStall(iStall),
    .branchTakenE(branchTakenE), .exc(exc), .queueFull(queueFull),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF), .stallD(stallD),
    .flushD(flushD), .flushE(flushE), .pcInSelect(pcInSelect),
    .retireValid(retireValid), .retireDest(retireDest)
  );

  always #50 clk = ~clk;

  // hard stop if the run does not finish in time
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("run did not finish within %0d cycles", cycleLimit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // hex digit i of a trace word, digit 0 on the left
  function automatic logic [3:0] digitOf(input logic [83:0] word, input int i);
    return 4'(word >> (80 - 4 * i));
  endfunction

  // low bit of hex digit i, for the one-bit fields
  function automatic logic flagOf(input logic [83:0] word, input int i);
    logic [3:0] digit;
    digit = digitOf(word, i);
    return digit[0];
  endfunction

  task automatic checkValue(input string name, input int line,
                            input logic [3:0] expected, input logic [3:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] line %0d %s expected %0h actual %0h", line, name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic failPlain(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "trace problem");
  endtask

  initial begin
    int fd;
    int loaded;
    logic [83:0] word;
    rst           = 1'b1;
    fetchValid    = 1'b0;
    fetchSrc1     = '0;
    fetchSrc2     = '0;
    fetchDest     = '0;
    fetchRegWrite = 1'b0;
    fetchMemToReg = 1'b0;
    dStall        = 1'b0;
    iStall        = 1'b0;
    branchTakenE  = 1'b0;
    exc           = '0;
    for (int i = 0; i < traceLen; i++) begin
      trace[i] = sentinel;
    end

    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      failPlain("the trace file could not be opened");
    end
    $fclose(fd);
    $readmemh(traceFile, trace);
    loaded = 0;
    while (loaded < traceLen && trace[loaded] !== sentinel) begin
      loaded++;
    end
    if (loaded < traceLen) begin
      failPlain($sformatf("the trace file holds %0d lines, %0d expected", loaded, traceLen));
    end

    // last reset edge is the one that applies line 0
    repeat (resetCycles - 1) @(posedge clk);

    for (int line = 0; line < traceLen; line++) begin
      word = trace[line];
      @(posedge clk);
      rst           <= 1'b0;
      fetchValid    <= flagOf(word, 0);
      fetchSrc1     <= digitOf(word, 1);
      fetchSrc2     <= digitOf(word, 2);
      fetchDest     <= digitOf(word, 3);
      fetchRegWrite <= flagOf(word, 4);
      fetchMemToReg <= flagOf(word, 5);
      dStall        <= flagOf(word, 6);
      iStall        <= flagOf(word, 7);
      branchTakenE  <= flagOf(word, 8);
      // cause bits are the low half of digit 9 and all of digit 10
      exc           <= word[45:40];
      // outputs settle by mid cycle
      @(negedge clk);
      checkValue("queueFull", line, digitOf(word, 11), 4'(queueFull));
      checkValue("forwardAE", line, digitOf(word, 12), 4'(forwardAE));
      checkValue("forwardBE", line, digitOf(word, 13), 4'(forwardBE));
      checkValue("stallF", line, digitOf(word, 14), 4'(stallF));
      checkValue("stallD", line, digitOf(word, 15), 4'(stallD));
      checkValue("flushD", line, digitOf(word, 16), 4'(flushD));
      checkValue("flushE", line, digitOf(word, 17), 4'(flushE));
      checkValue("pcInSelect", line, digitOf(word, 18), 4'(pcInSelect));
      checkValue("retireValid", line, digitOf(word, 19), 4'(retireValid));
      checkValue("retireDest", line, digitOf(word, 20), retireDest);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- bench/pipeCtrlTrace.txt
// one cycle per line, 21 hex digits: fetchValid src1 src2 dest regWrite memToReg
// dStall iStall branchTakenE exc(2) | queueFull fwdA fwdB stallF stallD flushD flushE vecSel retireValid retireDest
000000000000000000000 // reset state
000000000000000000000
112310000000000000000 // forwarding chain
134510000000000000000
135610000000000000000
111710000000000000000
172710000000200000000
177910000000120000013
000000000000000000015
000000000000200000016
000000000000220000017 // both match, memory wins
000000000000000000017
000000000000000000019
000000000000000000000
112411000000000000000 // load then consumer
143510000000000000000
000000000000000000000
000000000000001101000
000000000000000000000
000000000000100000014
000000000000000000000
000000000000000000015
000000000000000000000
112310000000000000000 // branch squashes the younger ones
123610000000000000000
134810000000000000000
144910001000000011000
000000000000000000000
000000000000000000013
000000000000000000000
112F10000000000000000 // pc write
123410000000000000000
135610000000001010000
000000000000001010000
000000000000001010000
00000000000000001001F
123810000000000000000 // data stall and a full queue
000000000000000000000
000000000000000000000
000000000000000000000
111100100000001100000
122200100000001100000
133300100000001100000
144400100000001100000
155500100001001100000
000000000001000000000
000000000000000000018
000000000000000000000
000000010000001110000 // instruction stall
000000010000001110000
000000000000000000000
000000000000000000011
000000000000000000012
000000000000000000000
000000000000000000014
000000000000000000000
000000000200000000000 // exception causes
000000000100000000200
000000000080000000000
000000000040000000000
000000000020000000100
000000000010000000100
000000000110000000200
000000000000000000000

//--- source/fetchQueue.sv
`include "pipeCtrl_macros.svh"

module fetchQueue import pipeCtrlPkg::*; #(
  parameter int depth = `QUEUE_DEPTH
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  logic   pop,
  input  logic   clear,
  input  regIdxT inSrc1,
  input  regIdxT inSrc2,
  input  regIdxT inDest,
  input  logic   inRegWrite,
  input  logic   inMemToReg,
  output regIdxT outSrc1,
  output regIdxT outSrc2,
  output regIdxT outDest,
  output logic   outRegWrite,
  output logic   outMemToReg,
  output logic   empty,
  output logic   full
);

  localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntBits = $clog2(depth + 1);

  // one stored descriptor
  typedef struct packed {
    regIdxT src1;
    regIdxT src2;
    regIdxT dest;
    logic   regWrite;
    logic   memToReg;
  } entryT;

  entryT              mem [depth];
  logic [ptrBits-1:0] rdPtr;
  logic [ptrBits-1:0] wrPtr;
  logic [cntBits-1:0] count;
  logic               doPush;
  logic               doPop;

  assign empty = (count == '0);
  assign full  = (count == cntBits'(depth));

  // a push while full only goes in when the head leaves on the same edge
  assign doPush = push & (~full | pop);
  assign doPop  = pop & ~empty;

  // head descriptor, meaningful only while not empty
  assign outSrc1     = mem[rdPtr].src1;
  assign outSrc2     = mem[rdPtr].src2;
  assign outDest     = mem[rdPtr].dest;
  assign outRegWrite = mem[rdPtr].regWrite;
  assign outMemToReg = mem[rdPtr].memToReg;

  // storage, written in place
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= '{inSrc1, inSrc2, inDest, inRegWrite, inMemToReg};
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      // redirect drops everything, including a push on the same edge
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/hazard.sv
module hazard import pipeCtrlPkg::*; (
  input  logic     match1EM,
  input  logic     match1EW,
  input  logic     match2EM,
  input  logic     match2EW,
  input  logic     match1DE,
  input  logic     match2DE,
  input  logic     regWriteM,
  input  logic     regWriteW,
  input  logic     memToRegE,
  input  logic     pcWrPendingF,
  input  logic     pcSrcW,
  input  logic     dStall,
  input  logic     iStall,
  input  logic     branchTakenE,
  input  excCauseT exc,
  output fwdSelT   forwardAE,
  output fwdSelT   forwardBE,
  output logic     stallF,
  output logic     stallD,
  output logic     stallE,
  output logic     stallM,
  output logic     stallW,
  output logic     flushD,
  output logic     flushE,
  output logic     flushW,
  output vecSelT   pcInSelect
);

  logic match12DE;
  logic ldrStallD;
  logic cacheStall;

  // memory stage result is the newer one so it wins
  always_comb begin
    if (match1EM && regWriteM) begin
      forwardAE = fwdFromM;
    end else if (match1EW && regWriteW) begin
      forwardAE = fwdFromW;
    end else begin
      forwardAE = fwdNone;
    end

    if (match2EM && regWriteM) begin
      forwardBE = fwdFromM;
    end else if (match2EW && regWriteW) begin
      forwardBE = fwdFromW;
    end else begin
      forwardBE = fwdNone;
    end
  end

  // load result not ready until memory, so hold decode one cycle
  assign match12DE = match1DE | match2DE;
  assign ldrStallD = match12DE & memToRegE;

  // either cache miss freezes the back of the pipe
  assign cacheStall = dStall | iStall;

  assign stallD = ldrStallD | cacheStall;
  // fetch also waits while a pc write is in flight
  assign stallF = stallD | pcWrPendingF;
  assign stallE = cacheStall;
  assign stallM = cacheStall;
  assign stallW = cacheStall;
  assign flushW = cacheStall;

  // bubble into execute behind a load, wrong-path squash on branch
  assign flushE = ldrStallD | branchTakenE;
  assign flushD = pcWrPendingF | pcSrcW | branchTakenE | iStall;

  // exception vector, prefetch abort checked first
  always_comb begin
    if (exc.prefetchAbort) begin
      pcInSelect = vecNormal;
    end else if (exc.dataAbort) begin
      pcInSelect = vecData;
    end else if (exc.irq || exc.fiq) begin
      pcInSelect = vecNormal;
    end else if (exc.undefInstr || exc.swi) begin
      pcInSelect = vecUndef;
    end else begin
      pcInSelect = vecNormal;
    end
  end

endmodule

//--- source/pipeCtrlPkg.sv
`include "pipeCtrl_macros.svh"

package pipeCtrlPkg;

  // register number as carried through the pipe
  typedef logic [`REG_BITS-1:0] regIdxT;

  // execute operand source
  typedef enum logic [1:0] {
    fwdNone  = 2'd0,
    fwdFromW = 2'd1,
    fwdFromM = 2'd2
  } fwdSelT;

  // pc mux select on an exception
  typedef enum logic [1:0] {
    vecNormal = 2'd0,
    vecUndef  = 2'd1,
    vecData   = 2'd2
  } vecSelT;

  // one bit per cause, prefetch abort in the msb
  typedef struct packed {
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
    logic undefInstr;
    logic swi;
  } excCauseT;

endpackage

//--- source/pipeCtrlTop.sv
module pipeCtrlTop import pipeCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     fetchValid,
  input  regIdxT   fetchSrc1,
  input  regIdxT   fetchSrc2,
  input  regIdxT   fetchDest,
  input  logic     fetchRegWrite,
  input  logic     fetchMemToReg,
  input  logic     dStall,
  input  logic     iStall,
  input  logic     branchTakenE,
  input  excCauseT exc,
  output logic     queueFull,
  output fwdSelT   forwardAE,
  output fwdSelT   forwardBE,
  output logic     stallF,
  output logic     stallD,
  output logic     flushD,
  output logic     flushE,
  output vecSelT   pcInSelect,
  output logic     retireValid,
  output regIdxT   retireDest
);

  // queue head
  regIdxT headSrc1;
  regIdxT headSrc2;
  regIdxT headDest;
  logic   headRegWrite;
  logic   headMemToReg;
  logic   queueEmpty;
  logic   queuePop;
  logic   popQueue;
  logic   redirect;

  // tracker conditions
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match1DE;
  logic match2DE;
  logic regWriteM;
  logic regWriteW;
  logic memToRegE;
  logic pcWrPendingF;
  logic pcSrcW;

  // stage controls that stay inside
  logic stallE;
  logic stallM;
  logic stallW;
  logic flushW;

  // fetch held means no pop, and a redirect empties the queue
  assign popQueue = queuePop & ~stallF;
  assign redirect = branchTakenE | pcSrcW;

  fetchQueue uQueue (
    .clk(clk), .rst(rst), .push(fetchValid), .pop(popQueue), .clear(redirect),
    .inSrc1(fetchSrc1), .inSrc2(fetchSrc2), .inDest(fetchDest),
    .inRegWrite(fetchRegWrite), .inMemToReg(fetchMemToReg),
    .outSrc1(headSrc1), .outSrc2(headSrc2), .outDest(headDest),
    .outRegWrite(headRegWrite), .outMemToReg(headMemToReg),
    .empty(queueEmpty), .full(queueFull)
  );

  stageTracker uTracker (
    .clk(clk), .rst(rst), .queueEmpty(queueEmpty),
    .headSrc1(headSrc1), .headSrc2(headSrc2), .headDest(headDest),
    .headRegWrite(headRegWrite), .headMemToReg(headMemToReg),
    .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushD(flushD), .flushE(flushE), .flushW(flushW), .queuePop(queuePop),
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM), .match2EW(match2EW),
    .match1DE(match1DE), .match2DE(match2DE), .regWriteM(regWriteM),
    .regWriteW(regWriteW), .memToRegE(memToRegE), .pcWrPendingF(pcWrPendingF),
    .pcSrcW(pcSrcW), .retireValid(retireValid), .retireDest(retireDest)
  );

  hazard uHazard (
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM), .match2EW(match2EW),
    .match1DE(match1DE), .match2DE(match2DE), .regWriteM(regWriteM),
    .regWriteW(regWriteW), .memToRegE(memToRegE), .pcWrPendingF(pcWrPendingF),
    .pcSrcW(pcSrcW), .dStall(dStall), .iStall(iStall), .branchTakenE(branchTakenE),
    .exc(exc), .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF),
    .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushD(flushD), .flushE(flushE), .flushW(flushW), .pcInSelect(pcInSelect)
  );

endmodule

//--- source/pipeCtrl_macros.svh
`ifndef PIPECTRL_MACROS_SVH
`define PIPECTRL_MACROS_SVH

// width of an architectural register number
`define REG_BITS 4

// r15 is the program counter
`define PC_REG 15

// fetch queue entries
`define QUEUE_DEPTH 4

`endif

//--- source/stageTracker.sv
`include "pipeCtrl_macros.svh"

module stageTracker import pipeCtrlPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   queueEmpty,
  input  regIdxT headSrc1,
  input  regIdxT headSrc2,
  input  regIdxT headDest,
  input  logic   headRegWrite,
  input  logic   headMemToReg,
  input  logic   stallD,
  input  logic   stallE,
  input  logic   stallM,
  input  logic   stallW,
  input  logic   flushD,
  input  logic   flushE,
  input  logic   flushW,
  output logic   queuePop,
  output logic   match1EM,
  output logic   match1EW,
  output logic   match2EM,
  output logic   match2EW,
  output logic   match1DE,
  output logic   match2DE,
  output logic   regWriteM,
  output logic   regWriteW,
  output logic   memToRegE,
  output logic   pcWrPendingF,
  output logic   pcSrcW,
  output logic   retireValid,
  output regIdxT retireDest
);

  // what each stage remembers about its instruction
  typedef struct packed {
    logic   valid;
    regIdxT src1;
    regIdxT src2;
    regIdxT dest;
    logic   regWrite;
    logic   memToReg;
  } stageT;

  localparam stageT bubble = '0;
  localparam regIdxT pcReg = regIdxT'(`PC_REG);

  stageT stD;
  stageT stE;
  stageT stM;
  stageT stW;
  stageT nextD;
  stageT nextE;
  stageT nextM;
  stageT nextW;
  stageT head;

  // decode takes the head whenever it is free to move
  assign queuePop = ~stallD & ~queueEmpty;
  assign head     = '{1'b1, headSrc1, headSrc2, headDest, headRegWrite, headMemToReg};

  // stage movement
  // flush beats stall, and a stage behind a stalled one gets a bubble
  always_comb begin
    if (flushD) begin
      nextD = bubble;
    end else if (stallD) begin
      nextD = stD;
    end else if (queuePop) begin
      nextD = head;
    end else begin
      // nothing queued
      nextD = bubble;
    end

    if (flushE) begin
      nextE = bubble;
    end else if (stallE) begin
      nextE = stE;
    end else if (stallD) begin
      nextE = bubble;
    end else begin
      nextE = stD;
    end

    // memory stage has no flush of its own
    if (stallM) begin
      nextM = stM;
    end else if (stallE) begin
      nextM = bubble;
    end else begin
      nextM = stE;
    end

    if (flushW) begin
      nextW = bubble;
    end else if (stallW) begin
      nextW = stW;
    end else if (stallM) begin
      nextW = bubble;
    end else begin
      nextW = stM;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stD <= bubble;
      stE <= bubble;
      stM <= bubble;
      stW <= bubble;
    end else begin
      stD <= nextD;
      stE <= nextE;
      stM <= nextM;
      stW <= nextW;
    end
  end

  // source of the earlier stage against dest of the later, later must be live
  assign match1EM = stM.valid & (stE.src1 == stM.dest);
  assign match1EW = stW.valid & (stE.src1 == stW.dest);
  assign match2EM = stM.valid & (stE.src2 == stM.dest);
  assign match2EW = stW.valid & (stE.src2 == stW.dest);
  assign match1DE = stE.valid & (stD.src1 == stE.dest);
  assign match2DE = stE.valid & (stD.src2 == stE.dest);

  // qualified control bits for the hazard unit
  assign regWriteM = stM.valid & stM.regWrite;
  assign regWriteW = stW.valid & stW.regWrite;
  assign memToRegE = stE.valid & stE.memToReg;

  // any pc write still in flight before writeback
  assign pcWrPendingF = (stD.valid & stD.regWrite & (stD.dest == pcReg))
                      | (stE.valid & stE.regWrite & (stE.dest == pcReg))
                      | (stM.valid & stM.regWrite & (stM.dest == pcReg));

  // pc write landing this cycle
  assign pcSrcW = stW.valid & stW.regWrite & (stW.dest == pcReg);

  assign retireValid = stW.valid;
  assign retireDest  = stW.dest;

endmodule

//--- tb.f
+incdir+source
source/pipeCtrlPkg.sv
source/fetchQueue.sv
source/stageTracker.sv
source/hazard.sv
source/pipeCtrlTop.sv
bench/pipeCtrlTb.sv
